// File: design/vt_cfg.svh
`ifndef VT_CFG_SVH
`define VT_CFG_SVH

// ----------------------------------------------------------------------
// pattern set
// ----------------------------------------------------------------------
`define VT_PAT_NUM          11      // patterns 0 to 10
`define VT_PAT_RESET        1       // white after reset
`define VT_GRAY_STEP        25      // level step between gray patterns

// ----------------------------------------------------------------------
// serial line and buttons
// ----------------------------------------------------------------------
`define VT_UART_DIV         8       // clocks per bit
`define VT_DEBOUNCE_CYCLES  8

// ----------------------------------------------------------------------
// dac loading
// ----------------------------------------------------------------------
`define VT_DAC_CREDITS      2       // loader queue depth
`define VT_DAC_WR_CYCLES    2       // wr strobe length
`define VT_DAC_SRC_CHAN     0       // channel carrying the source level

// panel timing
`define VT_LINE_CYCLES      16
`define VT_FRAME_LINES      12

`endif

// File: design/vt_ctrl_pkg.sv
`include "vt_cfg.svh"

package vt_ctrl_pkg;

    typedef enum logic [3:0] {
        PAT_BLACK = 4'd0,
        PAT_WHITE = 4'd1
    } pattern_e;                    // 2 to 10 are gray patterns

    typedef enum logic [7:0] {
        OP_SET_PAT = 8'h50,         // 'P', argument byte follows
        OP_NEXT    = 8'h4E,         // 'N'
        OP_PREV    = 8'h52          // 'R'
    } cmd_op_e;

    typedef struct packed {
        logic [1:0] chip;
        logic [1:0] chan;
        logic [7:0] code;
    } dac_req_t;

    typedef struct packed {
        logic       wr;
        logic [1:0] a;
        logic [7:0] din;
    } dac_port_t;                   // pins of one dac chip

    // gray level of a pattern
    function automatic logic [7:0] gray_level(pattern_e p);
        case (p)
            PAT_BLACK: return 8'd0;
            PAT_WHITE: return 8'd255;
            default:   return 8'((p - 4'd1) * `VT_GRAY_STEP);
        endcase
    endfunction

endpackage

// File: design/vt_panel_pkg.sv
package vt_panel_pkg;

    typedef struct packed {
        logic       stv;
        logic [3:0] ckv_l;
        logic [3:0] ckv_r;
        logic [2:0] ckh;
        logic       u2d;
        logic       d2u;
        logic       grst;
    } gate_sig_t;

    typedef logic [1:0] mux_code_t; // {right, left} switch select

    typedef struct packed {
        mux_code_t stv;
        mux_code_t ckv1;
        mux_code_t ckv2;
        mux_code_t ckv3;
        mux_code_t ckv4;
        mux_code_t ckh1;
        mux_code_t ckh2;
        mux_code_t ckh3;
        mux_code_t dir;             // u2d low, d2u high
        mux_code_t grst;
        mux_code_t gas;             // all gates on
    } panel_mux_t;

endpackage

// File: design/uart_rx.sv
`timescale 1ns/1ps
`include "vt_cfg.svh"

module uart_rx (
    input  logic       clk_sys,
    input  logic       arst_n,
    input  logic       rxd,
    output logic [7:0] rx_byte,
    output logic       rx_valid
);

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } rx_state_e;

    rx_state_e  state;
    logic [1:0] rxd_sync;
    logic [7:0] div_cnt;
    logic [2:0] bit_cnt;
    logic [7:0] shift;
    logic       bit_tick;

    assign bit_tick = (div_cnt == 8'(`VT_UART_DIV - 1));
    assign rx_byte  = shift;

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            rxd_sync <= 2'b11;              // line idles high
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
        end
    end

    // ----------------------------------------------------------------------
    // frame fsm, samples at bit centre
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state    <= RX_IDLE;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            div_cnt  <= div_cnt + 8'd1;
            case (state)
                RX_IDLE: begin
                    div_cnt <= '0;
                    if (!rxd_sync[1])
                        state <= RX_START;
                end
                RX_START: begin
                    if (div_cnt == 8'(`VT_UART_DIV / 2 - 1)) begin
                        div_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= rxd_sync[1] ? RX_IDLE : RX_DATA;  // glitch rejected
                    end
                end
                RX_DATA: begin
                    if (bit_tick) begin
                        div_cnt <= '0;
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7)
                            state <= RX_STOP;
                    end
                end
                default: begin
                    if (bit_tick) begin
                        state    <= RX_IDLE;
                        rx_valid <= rxd_sync[1];    // framing error drops byte
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk_sys) begin
        if (state == RX_DATA && bit_tick)
            shift <= {rxd_sync[1], shift[7:1]};    // lsb first
    end

    a_rx_valid_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
        rx_valid |=> !rx_valid);

endmodule

// File: design/pattern_ctrl.sv
`timescale 1ns/1ps
`include "vt_cfg.svh"

module pattern_ctrl (
    input  logic                  clk_sys,
    input  logic                  arst_n,
    input  logic                  sw_next,
    input  logic                  sw_prev,
    input  logic [7:0]            rx_byte,
    input  logic                  rx_valid,
    output vt_ctrl_pkg::pattern_e pattern,
    output vt_ctrl_pkg::dac_req_t dac_req,
    output logic                  dac_req_valid,
    input  logic                  dac_credit
);

    import vt_ctrl_pkg::*;

    localparam int CRED_W = $clog2(`VT_DAC_CREDITS + 1);

    typedef enum logic {
        PS_OP,
        PS_ARG
    } parse_state_e;

    parse_state_e      ps;
    logic [1:0]        btn_meta;
    logic [1:0]        btn_sync;
    logic [1:0]        btn_db;          // [0] next, [1] prev
    logic [1:0]        press;
    logic [7:0]        db_cnt [2];
    pattern_e          pat_nxt;
    logic              pat_chg;
    logic              pending;
    logic              busy;
    logic              start;
    logic              issue;
    logic [1:0]        chip_idx;
    logic [7:0]        level;
    logic [CRED_W-1:0] cred;

    function automatic pattern_e step(pattern_e p, logic up);
        if (up)
            return (p == pattern_e'(`VT_PAT_NUM - 1)) ? PAT_BLACK : pattern_e'(p + 4'd1);
        return (p == PAT_BLACK) ? pattern_e'(`VT_PAT_NUM - 1) : pattern_e'(p - 4'd1);
    endfunction

    // ----------------------------------------------------------------------
    // button debounce
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            btn_meta <= '0;
            btn_sync <= '0;
            btn_db   <= '0;
            press    <= '0;
            for (int i = 0; i < 2; i++) begin
                db_cnt[i] <= '0;
            end
        end else begin
            btn_meta <= {sw_prev, sw_next};
            btn_sync <= btn_meta;
            press    <= '0;
            for (int i = 0; i < 2; i++) begin
                if (btn_sync[i] == btn_db[i]) begin
                    db_cnt[i] <= '0;
                end else if (db_cnt[i] == 8'(`VT_DEBOUNCE_CYCLES - 1)) begin
                    db_cnt[i] <= '0;
                    btn_db[i] <= btn_sync[i];
                    press[i]  <= btn_sync[i];       // press edge only
                end else begin
                    db_cnt[i] <= db_cnt[i] + 8'd1;
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // command parser and pattern register
    // ----------------------------------------------------------------------
    always_comb begin
        pat_nxt = pattern;
        if (rx_valid && ps == PS_OP && rx_byte == OP_NEXT)
            pat_nxt = step(pattern, 1'b1);
        else if (rx_valid && ps == PS_OP && rx_byte == OP_PREV)
            pat_nxt = step(pattern, 1'b0);
        else if (rx_valid && ps == PS_ARG && rx_byte < 8'(`VT_PAT_NUM))
            pat_nxt = pattern_e'(rx_byte[3:0]);
        else if (press[0])
            pat_nxt = step(pattern, 1'b1);
        else if (press[1])
            pat_nxt = step(pattern, 1'b0);
    end

    assign pat_chg = (pat_nxt != pattern);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            ps      <= PS_OP;
            pattern <= pattern_e'(`VT_PAT_RESET);
        end else begin
            pattern <= pat_nxt;
            if (rx_valid)
                ps <= (ps == PS_OP && rx_byte == OP_SET_PAT) ? PS_ARG : PS_OP;
        end
    end

    // ----------------------------------------------------------------------
    // group sequencer, one request per credit
    // ----------------------------------------------------------------------
    assign start = !busy && pending;
    assign issue = busy && (cred != '0);

    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            pending       <= 1'b1;          // group after reset release
            busy          <= 1'b0;
            chip_idx      <= '0;
            cred          <= CRED_W'(`VT_DAC_CREDITS);
            dac_req_valid <= 1'b0;
        end else begin
            dac_req_valid <= issue;
            pending       <= pat_chg || (pending && busy);
            if (start) begin
                busy     <= 1'b1;
                chip_idx <= '0;
            end else if (issue) begin
                busy     <= (chip_idx != 2'd3);
                chip_idx <= chip_idx + 2'd1;
            end
            if (issue && !dac_credit)
                cred <= cred - CRED_W'(1);
            else if (!issue && dac_credit)
                cred <= cred + CRED_W'(1);
        end
    end

    always_ff @(posedge clk_sys) begin
        if (start)
            level <= gray_level(pattern);   // newest pattern wins
        if (issue)
            dac_req <= '{chip: chip_idx, chan: 2'(`VT_DAC_SRC_CHAN), code: level};
    end

    a_credit_bound: assert property (@(posedge clk_sys) disable iff (!arst_n)
        cred <= CRED_W'(`VT_DAC_CREDITS));

    a_no_req_at_zero: assert property (@(posedge clk_sys) disable iff (!arst_n)
        dac_req_valid |-> $past(cred) != '0);

endmodule

// File: design/dac_loader.sv
`timescale 1ns/1ps
`include "vt_cfg.svh"

module dac_loader (
    input  logic                         clk_sys,
    input  logic                         arst_n,
    input  vt_ctrl_pkg::dac_req_t        dac_req,
    input  logic                         dac_req_valid,
    output logic                         dac_credit,
    output vt_ctrl_pkg::dac_port_t [3:0] dac
);

    import vt_ctrl_pkg::*;

    localparam int DEPTH = `VT_DAC_CREDITS;
    localparam int AW    = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_STROBE,
        WS_HOLD
    } wr_state_e;

    wr_state_e     state;
    dac_req_t      fifo_mem [DEPTH];
    dac_req_t      cur;                 // write in progress
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   fill;
    logic [7:0]    wr_cyc;
    logic          pop;

    function automatic logic [AW-1:0] ptr_inc(logic [AW-1:0] p);
        return (p == AW'(DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign pop = (state == WS_IDLE) && (fill != '0);

    always_ff @(posedge clk_sys) begin
        if (dac_req_valid)
            fifo_mem[wr_ptr] <= dac_req;
        if (pop)
            cur <= fifo_mem[rd_ptr];
    end

    // ----------------------------------------------------------------------
    // queue pointers and write fsm
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            state      <= WS_IDLE;
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            fill       <= '0;
            wr_cyc     <= '0;
            dac_credit <= 1'b0;
        end else begin
            dac_credit <= 1'b0;
            fill       <= fill + (AW+1)'(dac_req_valid) - (AW+1)'(pop);
            if (dac_req_valid)
                wr_ptr <= ptr_inc(wr_ptr);
            if (pop)
                rd_ptr <= ptr_inc(rd_ptr);
            case (state)
                WS_IDLE: begin
                    wr_cyc <= '0;
                    if (pop)
                        state <= WS_STROBE;
                end
                WS_STROBE: begin
                    wr_cyc <= wr_cyc + 8'd1;
                    if (wr_cyc == 8'(`VT_DAC_WR_CYCLES - 1))
                        state <= WS_HOLD;
                end
                default: begin
                    state      <= WS_IDLE;
                    dac_credit <= 1'b1;     // lands in the idle cycle
                end
            endcase
        end
    end

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            dac[i].wr  = (state == WS_STROBE) && (cur.chip == 2'(i));
            dac[i].a   = cur.chan;
            dac[i].din = cur.code;
        end
    end

    a_one_wr: assert property (@(posedge clk_sys) disable iff (!arst_n)
        $onehot0({dac[3].wr, dac[2].wr, dac[1].wr, dac[0].wr}));

    // the credit loop keeps the queue from overflowing
    a_no_overflow: assert property (@(posedge clk_sys) disable iff (!arst_n)
        fill <= (AW+1)'(DEPTH));

endmodule

// File: design/gate_timing_gen.sv
`timescale 1ns/1ps
`include "vt_cfg.svh"

module gate_timing_gen (
    input  logic                     clk_sys,
    input  logic                     arst_n,
    input  vt_ctrl_pkg::pattern_e    pattern,
    output vt_panel_pkg::panel_mux_t panel_mux
);

    import vt_ctrl_pkg::*;
    import vt_panel_pkg::*;

    localparam int THIRD = `VT_LINE_CYCLES / 3;

    logic [7:0] cyc_cnt;
    logic [7:0] line_cnt;
    logic       black;
    gate_sig_t  gs;

    function automatic mux_code_t enc(logic left, logic right);
        return {right, left};
    endfunction

    assign black = (pattern == PAT_BLACK);

    // ----------------------------------------------------------------------
    // line and frame counters
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            cyc_cnt  <= '0;
            line_cnt <= '0;
        end else if (cyc_cnt == 8'(`VT_LINE_CYCLES - 1)) begin
            cyc_cnt  <= '0;
            line_cnt <= (line_cnt == 8'(`VT_FRAME_LINES - 1)) ? 8'd0 : line_cnt + 8'd1;
        end else begin
            cyc_cnt <= cyc_cnt + 8'd1;
        end
    end

    always_comb begin
        gs.stv    = (line_cnt == 8'd0);
        gs.ckv_l  = 4'b0001 << line_cnt[1:0];   // rotates every line
        gs.ckv_r  = 4'b0001 << line_cnt[1:0];
        gs.ckh[0] = (cyc_cnt < 8'(THIRD));
        gs.ckh[1] = (cyc_cnt >= 8'(THIRD)) && (cyc_cnt < 8'(2 * THIRD));
        gs.ckh[2] = (cyc_cnt >= 8'(2 * THIRD));
        gs.u2d    = 1'b1;                        // forward scan
        gs.d2u    = 1'b0;
        gs.grst   = 1'b0;
        if (black) begin
            gs.stv   = 1'b0;
            gs.ckv_l = '1;
            gs.ckv_r = '1;
            gs.grst  = 1'b1;
        end
    end

    // ----------------------------------------------------------------------
    // registered mux codes
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_sys or negedge arst_n) begin
        if (!arst_n) begin
            panel_mux <= '0;
        end else begin
            panel_mux.stv  <= enc(gs.stv, gs.stv);
            panel_mux.ckv1 <= enc(gs.ckv_l[0], gs.ckv_r[0]);
            panel_mux.ckv2 <= enc(gs.ckv_l[1], gs.ckv_r[1]);
            panel_mux.ckv3 <= enc(gs.ckv_l[2], gs.ckv_r[2]);
            panel_mux.ckv4 <= enc(gs.ckv_l[3], gs.ckv_r[3]);
            panel_mux.ckh1 <= enc(gs.ckh[0], gs.ckh[0]);
            panel_mux.ckh2 <= enc(gs.ckh[1], gs.ckh[1]);
            panel_mux.ckh3 <= enc(gs.ckh[2], gs.ckh[2]);
            panel_mux.dir  <= enc(gs.u2d, gs.d2u);
            panel_mux.grst <= enc(gs.grst, gs.grst);
            panel_mux.gas  <= enc(black, black);
        end
    end

endmodule

// File: design/vt_demo_top.sv
`timescale 1ns/1ps

module vt_demo_top (
    input  logic                         clk_sys,
    input  logic                         arst_n,
    input  logic                         sw_next,
    input  logic                         sw_prev,
    input  logic                         rxd,
    output vt_ctrl_pkg::dac_port_t [3:0] dac,
    output vt_panel_pkg::panel_mux_t     panel_mux
);

    import vt_ctrl_pkg::*;

    logic [7:0] rx_byte;
    logic       rx_valid;
    pattern_e   pattern;
    dac_req_t   dac_req;
    logic       dac_req_valid;
    logic       dac_credit;

    uart_rx uart_rx_inst (
        .clk_sys  ( clk_sys  ),
        .arst_n   ( arst_n   ),
        .rxd      ( rxd      ),
        .rx_byte  ( rx_byte  ),
        .rx_valid ( rx_valid )
    );

    pattern_ctrl pattern_ctrl_inst (
        .clk_sys       ( clk_sys       ),
        .arst_n        ( arst_n        ),
        .sw_next       ( sw_next       ),
        .sw_prev       ( sw_prev       ),
        .rx_byte       ( rx_byte       ),
        .rx_valid      ( rx_valid      ),
        .pattern       ( pattern       ),
        .dac_req       ( dac_req       ),
        .dac_req_valid ( dac_req_valid ),
        .dac_credit    ( dac_credit    )    // credit return
    );

    dac_loader dac_loader_inst (
        .clk_sys       ( clk_sys       ),
        .arst_n        ( arst_n        ),
        .dac_req       ( dac_req       ),
        .dac_req_valid ( dac_req_valid ),
        .dac_credit    ( dac_credit    ),
        .dac           ( dac           )
    );

    gate_timing_gen gate_timing_gen_inst (
        .clk_sys   ( clk_sys   ),
        .arst_n    ( arst_n    ),
        .pattern   ( pattern   ),
        .panel_mux ( panel_mux )
    );

endmodule

// File: bench/tb_vt_demo.sv
`timescale 1ns/1ps
`include "vt_cfg.svh"

module tb_vt_demo;

    import vt_ctrl_pkg::*;
    import vt_panel_pkg::*;

    localparam int CLK_NS    = 20;
    localparam int FRAME_CYC = 10 * `VT_UART_DIV;                 // one serial byte
    localparam int GROUP_CYC = 4 * (`VT_DAC_WR_CYCLES + 2) + 8;   // four writes plus slack
    localparam int QUIET_CYC = 3 * GROUP_CYC;
    localparam int CMD_CYC   = 2 * FRAME_CYC + 16 + QUIET_CYC + GROUP_CYC;
    localparam int PRESS_CYC = 2 * (`VT_DEBOUNCE_CYCLES + 20) + QUIET_CYC + GROUP_CYC;
    localparam int GATE_CYC  = `VT_FRAME_LINES * `VT_LINE_CYCLES;
    localparam int TEST_CYC  = (GROUP_CYC + QUIET_CYC) + 40 * CMD_CYC
                             + (CMD_CYC + 22 * PRESS_CYC)
                             + (10 * FRAME_CYC + QUIET_CYC + 6 * GROUP_CYC)
                             + (CMD_CYC + 3 * GATE_CYC) + (CMD_CYC + 4);
    localparam longint WATCHDOG_NS = 2 * longint'(TEST_CYC) * CLK_NS;

    logic            clk_sys;
    logic            arst_n;
    logic            sw_next;
    logic            sw_prev;
    logic            rxd;
    dac_port_t [3:0] dac;
    panel_mux_t      panel_mux;

    string           test_name;
    int              model_pat = `VT_PAT_RESET;
    int              cyc       = 0;
    int              last_rise = 0;     // cycle of the newest wr rise
    int              grp_base  = 0;     // first write not yet checked
    logic [3:0]      wr_prev   = '0;
    dac_req_t        writes [$];

    vt_demo_top vt_demo_top_inst (
        .clk_sys   ( clk_sys   ),
        .arst_n    ( arst_n    ),
        .sw_next   ( sw_next   ),
        .sw_prev   ( sw_prev   ),
        .rxd       ( rxd       ),
        .dac       ( dac       ),
        .panel_mux ( panel_mux )
    );

    initial begin
        clk_sys = 1'b0;
        forever #(CLK_NS / 2) clk_sys = ~clk_sys;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns before the tests completed", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "timeout");
    end

    task automatic expect_eq(input string what, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("Fail %s, %s: expected %0d, actual %0d", test_name, what, exp, act);
            $display("TESTS FAILED");
            $fatal(1, "mismatch");
        end
    endtask

    // ----------------------------------------------------------------------
    // reference model
    // ----------------------------------------------------------------------
    function automatic int level_of(input int p);
        if (p == 0)
            return 0;
        if (p == 1)
            return 255;
        return (p - 1) * `VT_GRAY_STEP;
    endfunction

    function automatic int wrap_step(input int p, input int dir);
        return (p + dir + `VT_PAT_NUM) % `VT_PAT_NUM;
    endfunction

    always @(posedge clk_sys)
        cyc = cyc + 1;

    // dac write monitor, outputs are stable at the falling edge
    always @(negedge clk_sys) begin
        if (arst_n) begin
            expect_eq("single wr high", 1,
                      32'($onehot0({dac[3].wr, dac[2].wr, dac[1].wr, dac[0].wr})));
            for (int i = 0; i < 4; i++) begin
                if (dac[i].wr && !wr_prev[i]) begin
                    writes.push_back('{chip: 2'(i), chan: dac[i].a, code: dac[i].din});
                    last_rise = cyc;
                end
            end
            wr_prev = {dac[3].wr, dac[2].wr, dac[1].wr, dac[0].wr};
        end
    end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};                // stop, data lsb first, start
        for (int i = 0; i < 10; i++) begin
            @(negedge clk_sys);
            rxd = frame[i];
            repeat (`VT_UART_DIV - 1) @(negedge clk_sys);
        end
    endtask

    task automatic set_pattern(input int p);
        send_byte(OP_SET_PAT);
        send_byte(8'(p));
        model_pat = p;
    endtask

    task automatic send_cmd(input int kind);
        logic [7:0] val;
        case (kind)
            0: begin
                send_byte(OP_NEXT);
                model_pat = wrap_step(model_pat, 1);
            end
            1: begin
                send_byte(OP_PREV);
                model_pat = wrap_step(model_pat, -1);
            end
            2: set_pattern($urandom_range(0, `VT_PAT_NUM - 1));
            3: begin
                send_byte(OP_SET_PAT);
                send_byte(8'($urandom_range(`VT_PAT_NUM, 255)));  // out of range
            end
            default: begin
                do
                    val = 8'($urandom);
                while (val == OP_SET_PAT || val == OP_NEXT || val == OP_PREV);
                send_byte(val);                                    // unknown opcode
            end
        endcase
    endtask

    task automatic press_button(input logic up);
        int hold;
        hold = `VT_DEBOUNCE_CYCLES + 4 + $urandom_range(0, 15);
        @(negedge clk_sys);
        if (up)
            sw_next = 1'b1;
        else
            sw_prev = 1'b1;
        repeat (hold) @(negedge clk_sys);
        sw_next = 1'b0;
        sw_prev = 1'b0;
        repeat (hold) @(negedge clk_sys);   // release is debounced too
        model_pat = wrap_step(model_pat, up ? 1 : -1);
    endtask

    // ----------------------------------------------------------------------
    // response checks
    // ----------------------------------------------------------------------
    task automatic wait_quiet();
        int mark;
        mark = cyc;
        while (cyc - ((last_rise > mark) ? last_rise : mark) < QUIET_CYC)
            @(negedge clk_sys);
    endtask

    task automatic check_groups(input int min_grp, input int max_grp);
        int n;
        n = writes.size() - grp_base;
        expect_eq("writes in whole groups", 0, n % 4);
        expect_eq("enough groups", 1, 32'(n / 4 >= min_grp));
        expect_eq("not too many groups", 1, 32'(n / 4 <= max_grp));
        for (int i = grp_base; i < writes.size(); i++) begin
            expect_eq("write chip", (i - grp_base) % 4, 32'(writes[i].chip));
            expect_eq("write channel", `VT_DAC_SRC_CHAN, 32'(writes[i].chan));
            expect_eq("level within group", 32'(writes[i - (i - grp_base) % 4].code),
                      32'(writes[i].code));
        end
        expect_eq("last group level", level_of(model_pat),
                  32'(writes[writes.size() - 1].code));
        grp_base = writes.size();
    endtask

    task automatic settle_and_check(input int old_pat);
        int chg;
        chg = (old_pat != model_pat) ? 1 : 0;   // one group per change
        wait_quiet();
        check_groups(chg, chg);
    endtask

    function automatic mux_code_t ckv_code(input panel_mux_t pm, input int k);
        case (k)
            0:       return pm.ckv1;
            1:       return pm.ckv2;
            2:       return pm.ckv3;
            default: return pm.ckv4;
        endcase
    endfunction

    function automatic mux_code_t ckh_code(input panel_mux_t pm, input int j);
        case (j)
            0:       return pm.ckh1;
            1:       return pm.ckh2;
            default: return pm.ckh3;
        endcase
    endfunction

    task automatic measure_frame();
        panel_mux_t prev;
        int         rises;
        int         t_first;
        logic [5:0] ckh_bits;
        int         order [$];
        int         ckh_order [$];
        prev    = panel_mux;
        rises   = 0;
        t_first = 0;
        while (rises < 2) begin
            @(negedge clk_sys);
            if (panel_mux.stv != 2'b00 && prev.stv == 2'b00) begin
                rises++;
                if (rises == 1)
                    t_first = cyc;
                else
                    expect_eq("stv period", GATE_CYC, cyc - t_first);
            end
            for (int k = 0; k < 4; k++) begin
                if (rises == 1 && ckv_code(panel_mux, k) != 0 && ckv_code(prev, k) == 0)
                    order.push_back(k + 1);
            end
            for (int j = 0; j < 3; j++) begin
                if (rises == 1 && ckh_code(panel_mux, j) != 0 && ckh_code(prev, j) == 0)
                    ckh_order.push_back(j + 1);
            end
            ckh_bits = {panel_mux.ckh3, panel_mux.ckh2, panel_mux.ckh1};
            expect_eq("one ckh active", 1,
                      32'(ckh_bits inside {6'b000011, 6'b001100, 6'b110000}));
            prev = panel_mux;
        end
        expect_eq("ckv rises seen", 1, 32'(order.size() >= 4));
        for (int i = 0; i < 4; i++)
            expect_eq("ckv rise order", i + 1, order[i]);
        expect_eq("ckh rises per frame", 3 * `VT_FRAME_LINES, ckh_order.size());
        for (int i = 0; i < ckh_order.size(); i++)
            expect_eq("ckh rise order", i % 3 + 1, ckh_order[i]);
        expect_eq("dir code", 1, 32'(panel_mux.dir));    // forward scan
    endtask

    initial begin
        int old_pat;
        arst_n  = 1'b0;
        sw_next = 1'b0;
        sw_prev = 1'b0;
        rxd     = 1'b1;                     // line idle
        void'($urandom(45192));
        repeat (2) @(negedge clk_sys);
        arst_n = 1'b1;

        test_name = "reset group";
        wait_quiet();
        expect_eq("writes after reset", 4, writes.size());
        check_groups(1, 1);

        test_name = "serial commands";
        repeat (40) begin
            old_pat = model_pat;
            send_cmd($urandom_range(0, 4));
            repeat ($urandom_range(0, 15)) @(negedge clk_sys);
            settle_and_check(old_pat);
        end

        test_name = "buttons";
        old_pat = model_pat;
        set_pattern(`VT_PAT_NUM - 1);
        settle_and_check(old_pat);
        old_pat = model_pat;
        press_button(1'b1);                 // wraps to black
        settle_and_check(old_pat);
        old_pat = model_pat;
        press_button(1'b0);                 // wraps back to the top
        settle_and_check(old_pat);
        repeat (20) begin
            old_pat = model_pat;
            press_button(1'($urandom_range(0, 1)));
            settle_and_check(old_pat);
        end

        test_name = "back to back commands";
        repeat (5)
            send_cmd($urandom_range(0, 2));
        wait_quiet();
        check_groups(0, 6);

        test_name = "gray gate timing";
        old_pat = model_pat;
        set_pattern(5);
        settle_and_check(old_pat);
        measure_frame();

        test_name = "black all gates on";
        old_pat = model_pat;
        set_pattern(0);
        settle_and_check(old_pat);
        @(negedge clk_sys);
        expect_eq("stv code", 0, 32'(panel_mux.stv));
        for (int k = 0; k < 4; k++)
            expect_eq("ckv code", 3, 32'(ckv_code(panel_mux, k)));
        expect_eq("grst code", 3, 32'(panel_mux.grst));
        expect_eq("gas code", 3, 32'(panel_mux.gas));

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// File: build.f
+incdir+design
design/vt_ctrl_pkg.sv
design/vt_panel_pkg.sv
design/uart_rx.sv
design/pattern_ctrl.sv
design/dac_loader.sv
design/gate_timing_gen.sv
design/vt_demo_top.sv
bench/tb_vt_demo.sv

// File: Makefile
TOP := tb_vt_demo

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f build.f --top-module vt_demo_top

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTS PASSED"

clean:
	rm -rf obj_dir
